// File: rtl/ifu_pkg.sv
package ifu_pkg;

    localparam int FIFO_DEPTH = 16;   // instruction buffer entries
    localparam int PTR_W      = 4;    // buffer pointer and count width
    localparam int FULL_LEVEL = 12;   // room left for an in-flight pair plus one more
    localparam int XLEN       = 32;

    // major opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b,
        OP_OTHER   = 6'h3f
    } opcode_t;

    // fetch exception per issued slot, refill wins over invalid
    typedef enum logic [1:0] {
        EXC_NONE        = 2'd0,
        EXC_TLB_REFILL  = 2'd1,
        EXC_TLB_INVALID = 2'd2
    } exc_t;

endpackage

// File: rtl/fetch_unit.sv
module fetch_unit (
    input  logic                     clk,
    input  logic                     fifo_rst,
    input  logic                     full,
    input  logic                     empty,
    input  logic                     redirect,
    input  logic [ifu_pkg::XLEN-1:0] redirect_pc,
    input  logic                     delay_owed,
    input  logic [ifu_pkg::XLEN-1:0] slot_pc,
    output logic                     imem_req,
    output logic [ifu_pkg::XLEN-1:0] imem_addr,
    output logic                     imem_single,
    input  logic [ifu_pkg::XLEN-1:0] imem_rdata1,
    input  logic [ifu_pkg::XLEN-1:0] imem_rdata2,
    input  logic                     imem_refill1,
    input  logic                     imem_refill2,
    input  logic                     imem_invalid1,
    input  logic                     imem_invalid2,
    output logic                     write_en1,
    output logic                     write_en2,
    output logic [ifu_pkg::XLEN-1:0] write_addr1,
    output logic [ifu_pkg::XLEN-1:0] write_addr2,
    output logic [ifu_pkg::XLEN-1:0] write_data1,
    output logic [ifu_pkg::XLEN-1:0] write_data2,
    output logic                     write_refill1,
    output logic                     write_refill2,
    output logic                     write_invalid1,
    output logic                     write_invalid2
);

    logic [ifu_pkg::XLEN-1:0] pc;
    logic [ifu_pkg::XLEN-1:0] resume_pc;   // redirect target parked behind a slot refetch
    logic                     resume;
    logic                     running;     // idle until the first redirect supplies a pc
    logic                     inf_valid;
    logic [ifu_pkg::XLEN-1:0] inf_addr;
    logic                     inf_single;
    logic                     refetch;

    assign refetch     = delay_owed && empty;   // owed slot not in the buffer
    assign imem_req    = running && !full;
    assign imem_addr   = pc;
    assign imem_single = pc[2] || resume;       // odd word, or the lone delay slot

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            running <= 1'b0;
            resume  <= 1'b0;
            pc      <= '0;
        end else if (redirect) begin
            running <= 1'b1;
            resume  <= refetch;
            pc      <= refetch ? slot_pc : redirect_pc;
        end else if (imem_req) begin
            resume <= 1'b0;
            if (resume)
                pc <= resume_pc;
            else
                pc <= pc + (pc[2] ? 32'd4 : 32'd8);
        end
    end

    always_ff @(posedge clk) begin
        if (redirect)
            resume_pc <= redirect_pc;
    end

    // one answer in flight at most, a redirect kills it
    always_ff @(posedge clk) begin
        if (fifo_rst)
            inf_valid <= 1'b0;
        else
            inf_valid <= imem_req && !redirect;
    end

    always_ff @(posedge clk) begin
        inf_addr   <= pc;
        inf_single <= imem_single;
    end

    assign write_en1      = inf_valid && !redirect;
    assign write_en2      = write_en1 && !inf_single;
    assign write_addr1    = inf_addr;
    assign write_addr2    = inf_addr + 32'd4;
    assign write_data1    = imem_rdata1;
    assign write_data2    = imem_rdata2;
    assign write_refill1  = imem_refill1;
    assign write_refill2  = imem_refill2;
    assign write_invalid1 = imem_invalid1;
    assign write_invalid2 = imem_invalid2;

    // a second word is written only for a pair that was asked for
    assert property (@(posedge clk) disable iff (fifo_rst)
        write_en2 |-> write_en1 && $past(imem_req && !imem_single));

endmodule

// File: rtl/inst_fifo.sv
module inst_fifo (
    input  logic                     clk,
    input  logic                     fifo_rst,
    input  logic                     redirect,
    input  logic                     delay_owed,
    input  logic                     write_en1,
    input  logic                     write_en2,
    input  logic [ifu_pkg::XLEN-1:0] write_addr1,
    input  logic [ifu_pkg::XLEN-1:0] write_addr2,
    input  logic [ifu_pkg::XLEN-1:0] write_data1,
    input  logic [ifu_pkg::XLEN-1:0] write_data2,
    input  logic                     write_refill1,
    input  logic                     write_refill2,
    input  logic                     write_invalid1,
    input  logic                     write_invalid2,
    input  logic                     read_en1,
    input  logic                     read_en2,
    output logic                     head_valid1,
    output logic                     head_valid2,
    output logic [ifu_pkg::XLEN-1:0] head_addr1,
    output logic [ifu_pkg::XLEN-1:0] head_addr2,
    output logic [ifu_pkg::XLEN-1:0] head_data1,
    output logic [ifu_pkg::XLEN-1:0] head_data2,
    output logic                     head_refill1,
    output logic                     head_refill2,
    output logic                     head_invalid1,
    output logic                     head_invalid2,
    output logic                     empty,
    output logic                     full
);

    logic [ifu_pkg::XLEN-1:0]  line_addr    [ifu_pkg::FIFO_DEPTH];
    logic [ifu_pkg::XLEN-1:0]  line_data    [ifu_pkg::FIFO_DEPTH];
    logic                      line_refill  [ifu_pkg::FIFO_DEPTH];
    logic                      line_invalid [ifu_pkg::FIFO_DEPTH];

    logic [ifu_pkg::PTR_W-1:0] wr_ptr;
    logic [ifu_pkg::PTR_W-1:0] rd_ptr;
    logic [ifu_pkg::PTR_W-1:0] count;
    logic [ifu_pkg::PTR_W-1:0] wr_next;
    logic [ifu_pkg::PTR_W-1:0] rd_next;
    logic [ifu_pkg::PTR_W-1:0] wr_num;
    logic [ifu_pkg::PTR_W-1:0] rd_num;

    // delay slot kept across a flush
    logic                      held_valid;
    logic [ifu_pkg::XLEN-1:0]  held_addr;
    logic [ifu_pkg::XLEN-1:0]  held_data;
    logic                      held_refill;
    logic                      held_invalid;

    assign empty   = (count == '0);
    assign full    = (count >= ifu_pkg::FULL_LEVEL);
    assign wr_next = wr_ptr + 1'b1;
    assign rd_next = rd_ptr + 1'b1;
    assign wr_num  = write_en1 + write_en2;
    assign rd_num  = held_valid ? '0 : read_en1 + read_en2;   // held slot leaves the ring alone

    // held slot sits alone at the head
    assign head_valid1   = held_valid || !empty;
    assign head_valid2   = !held_valid && (count[ifu_pkg::PTR_W-1:1] != '0);
    assign head_addr1    = held_valid ? held_addr : line_addr[rd_ptr];
    assign head_data1    = held_valid ? held_data : line_data[rd_ptr];
    assign head_refill1  = held_valid ? held_refill : line_refill[rd_ptr];
    assign head_invalid1 = held_valid ? held_invalid : line_invalid[rd_ptr];
    assign head_addr2    = line_addr[rd_next];
    assign head_data2    = line_data[rd_next];
    assign head_refill2  = line_refill[rd_next];
    assign head_invalid2 = line_invalid[rd_next];

    always_ff @(posedge clk) begin
        if (write_en1) begin
            line_addr[wr_ptr]    <= write_addr1;
            line_data[wr_ptr]    <= write_data1;
            line_refill[wr_ptr]  <= write_refill1;
            line_invalid[wr_ptr] <= write_invalid1;
        end
        if (write_en2) begin
            line_addr[wr_next]    <= write_addr2;
            line_data[wr_next]    <= write_data2;
            line_refill[wr_next]  <= write_refill2;
            line_invalid[wr_next] <= write_invalid2;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            held_valid <= 1'b0;
        end else if (redirect) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            held_valid <= delay_owed && head_valid1;   // head is the owed slot
        end else begin
            wr_ptr <= wr_ptr + wr_num;
            rd_ptr <= rd_ptr + rd_num;
            count  <= count + wr_num - rd_num;
            if (held_valid && read_en1)
                held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect) begin
            held_addr    <= head_addr1;
            held_data    <= head_data1;
            held_refill  <= head_refill1;
            held_invalid <= head_invalid1;
        end
    end

    // the fetch side saw full low when it asked
    assert property (@(posedge clk) disable iff (fifo_rst)
        write_en1 |-> $past(!full));

    assert property (@(posedge clk) disable iff (fifo_rst)
        read_en2 |-> read_en1);

    assert property (@(posedge clk) disable iff (fifo_rst)
        read_en1 |-> !empty || held_valid);

endmodule

// File: rtl/issue_decode.sv
module issue_decode (
    input  logic                     clk,
    input  logic                     fifo_rst,
    input  logic                     redirect,
    input  logic                     issue_ready,
    input  logic                     head_valid1,
    input  logic                     head_valid2,
    input  logic [ifu_pkg::XLEN-1:0] head_addr1,
    input  logic [ifu_pkg::XLEN-1:0] head_addr2,
    input  logic [ifu_pkg::XLEN-1:0] head_data1,
    input  logic [ifu_pkg::XLEN-1:0] head_data2,
    input  logic                     head_refill1,
    input  logic                     head_refill2,
    input  logic                     head_invalid1,
    input  logic                     head_invalid2,
    output logic                     read_en1,
    output logic                     read_en2,
    output logic                     delay_owed,
    output logic [ifu_pkg::XLEN-1:0] slot_pc,
    output logic                     iss_valid1,
    output logic                     iss_valid2,
    output logic [ifu_pkg::XLEN-1:0] iss_pc1,
    output logic [ifu_pkg::XLEN-1:0] iss_pc2,
    output logic [ifu_pkg::XLEN-1:0] iss_instr1,
    output logic [ifu_pkg::XLEN-1:0] iss_instr2,
    output logic                     iss_refill1,
    output logic                     iss_refill2,
    output logic                     iss_invalid1,
    output logic                     iss_invalid2,
    output logic                     iss_delay1,
    output logic                     iss_branch1
);

    function automatic ifu_pkg::opcode_t decode_op(input logic [ifu_pkg::XLEN-1:0] instr);
        case (instr[31:26])
            6'h00:   decode_op = ifu_pkg::OP_SPECIAL;
            6'h02:   decode_op = ifu_pkg::OP_J;
            6'h03:   decode_op = ifu_pkg::OP_JAL;
            6'h04:   decode_op = ifu_pkg::OP_BEQ;
            6'h05:   decode_op = ifu_pkg::OP_BNE;
            6'h09:   decode_op = ifu_pkg::OP_ADDIU;
            6'h23:   decode_op = ifu_pkg::OP_LW;
            6'h2b:   decode_op = ifu_pkg::OP_SW;
            default: decode_op = ifu_pkg::OP_OTHER;
        endcase
    endfunction

    // written register, 0 when nothing is written
    function automatic logic [4:0] dest_of(input ifu_pkg::opcode_t op,
                                           input logic [ifu_pkg::XLEN-1:0] instr);
        case (op)
            ifu_pkg::OP_SPECIAL:           dest_of = instr[15:11];
            ifu_pkg::OP_ADDIU, ifu_pkg::OP_LW: dest_of = instr[20:16];
            ifu_pkg::OP_JAL:               dest_of = 5'd31;   // link register
            default:                       dest_of = 5'd0;
        endcase
    endfunction

    ifu_pkg::opcode_t op1;
    ifu_pkg::opcode_t op2;
    logic             br1;
    logic             br2;
    logic [4:0]       dest1;
    logic             uses_rs2;
    logic             uses_rt2;
    logic             raw_dep;
    logic             master_go;
    logic             slave_go;

    assign op1      = decode_op(head_data1);
    assign op2      = decode_op(head_data2);
    assign br1      = op1 inside {ifu_pkg::OP_J, ifu_pkg::OP_JAL, ifu_pkg::OP_BEQ, ifu_pkg::OP_BNE};
    assign br2      = op2 inside {ifu_pkg::OP_J, ifu_pkg::OP_JAL, ifu_pkg::OP_BEQ, ifu_pkg::OP_BNE};
    assign dest1    = dest_of(op1, head_data1);
    assign uses_rs2 = !(op2 inside {ifu_pkg::OP_J, ifu_pkg::OP_JAL});
    assign uses_rt2 = op2 inside {ifu_pkg::OP_SPECIAL, ifu_pkg::OP_SW, ifu_pkg::OP_OTHER};
    assign raw_dep  = (dest1 != 5'd0) && ((uses_rs2 && head_data2[25:21] == dest1) ||
                                          (uses_rt2 && head_data2[20:16] == dest1));

    // nothing issues in the redirect cycle, the head may be wrong path
    assign master_go = issue_ready && head_valid1 && !redirect;
    assign slave_go  = master_go && head_valid2 && !br1 && !br2 && !raw_dep && !delay_owed;

    assign read_en1     = master_go;
    assign read_en2     = slave_go;
    assign iss_valid1   = master_go;
    assign iss_valid2   = slave_go;
    assign iss_pc1      = head_addr1;
    assign iss_pc2      = head_addr2;
    assign iss_instr1   = head_data1;
    assign iss_instr2   = head_data2;
    assign iss_refill1  = head_refill1;
    assign iss_refill2  = head_refill2;
    assign iss_invalid1 = head_invalid1;
    assign iss_invalid2 = head_invalid2;
    assign iss_delay1   = delay_owed;   // master right after a branch
    assign iss_branch1  = br1;

    // owed until the next master goes, a redirect leaves it alone
    always_ff @(posedge clk) begin
        if (fifo_rst)
            delay_owed <= 1'b0;
        else if (master_go)
            delay_owed <= br1;
    end

    always_ff @(posedge clk) begin
        if (master_go && br1)
            slot_pc <= head_addr1 + 32'd4;
    end

endmodule

// File: rtl/issue_result.sv
module issue_result (
    input  logic                     clk,
    input  logic                     fifo_rst,
    input  logic                     iss_valid1,
    input  logic                     iss_valid2,
    input  logic [ifu_pkg::XLEN-1:0] iss_pc1,
    input  logic [ifu_pkg::XLEN-1:0] iss_pc2,
    input  logic [ifu_pkg::XLEN-1:0] iss_instr1,
    input  logic [ifu_pkg::XLEN-1:0] iss_instr2,
    input  logic                     iss_refill1,
    input  logic                     iss_refill2,
    input  logic                     iss_invalid1,
    input  logic                     iss_invalid2,
    input  logic                     iss_delay1,
    input  logic                     iss_branch1,
    output logic                     slot0_valid,
    output logic [ifu_pkg::XLEN-1:0] slot0_pc,
    output logic [ifu_pkg::XLEN-1:0] slot0_instr,
    output ifu_pkg::exc_t            slot0_exc,
    output logic                     slot0_delay,
    output logic                     slot1_valid,
    output logic [ifu_pkg::XLEN-1:0] slot1_pc,
    output logic [ifu_pkg::XLEN-1:0] slot1_instr,
    output ifu_pkg::exc_t            slot1_exc,
    output logic [31:0]              master_cnt,
    output logic [31:0]              slave_cnt
);

    function automatic ifu_pkg::exc_t exc_of(input logic refill, input logic invalid);
        if (refill)
            return ifu_pkg::EXC_TLB_REFILL;
        else if (invalid)
            return ifu_pkg::EXC_TLB_INVALID;
        else
            return ifu_pkg::EXC_NONE;
    endfunction

    logic last_branch;   // last issued master was a branch

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            slot0_valid <= 1'b0;
            slot1_valid <= 1'b0;
            master_cnt  <= '0;
            slave_cnt   <= '0;
            last_branch <= 1'b0;
        end else begin
            slot0_valid <= iss_valid1;
            slot1_valid <= iss_valid2;
            master_cnt  <= master_cnt + iss_valid1;
            slave_cnt   <= slave_cnt + iss_valid2;
            if (iss_valid1)
                last_branch <= iss_branch1;
        end
    end

    always_ff @(posedge clk) begin
        slot0_pc    <= iss_pc1;
        slot0_instr <= iss_instr1;
        slot0_exc   <= exc_of(iss_refill1, iss_invalid1);
        slot0_delay <= iss_delay1;
        slot1_pc    <= iss_pc2;
        slot1_instr <= iss_instr2;
        slot1_exc   <= exc_of(iss_refill2, iss_invalid2);
    end

    assert property (@(posedge clk) disable iff (fifo_rst)
        slot1_valid |-> slot0_valid);

    // a delay slot only ever follows a branch master, even across a flush
    assert property (@(posedge clk) disable iff (fifo_rst)
        iss_valid1 && iss_delay1 |-> last_branch);

endmodule

// File: rtl/ifu_top.sv
module ifu_top (
    input  logic                     clk,
    input  logic                     fifo_rst,
    input  logic                     issue_ready,
    input  logic                     redirect,
    input  logic [ifu_pkg::XLEN-1:0] redirect_pc,
    output logic                     imem_req,
    output logic [ifu_pkg::XLEN-1:0] imem_addr,
    output logic                     imem_single,
    input  logic [ifu_pkg::XLEN-1:0] imem_rdata1,
    input  logic [ifu_pkg::XLEN-1:0] imem_rdata2,
    input  logic                     imem_refill1,
    input  logic                     imem_refill2,
    input  logic                     imem_invalid1,
    input  logic                     imem_invalid2,
    output logic                     slot0_valid,
    output logic [ifu_pkg::XLEN-1:0] slot0_pc,
    output logic [ifu_pkg::XLEN-1:0] slot0_instr,
    output ifu_pkg::exc_t            slot0_exc,
    output logic                     slot0_delay,
    output logic                     slot1_valid,
    output logic [ifu_pkg::XLEN-1:0] slot1_pc,
    output logic [ifu_pkg::XLEN-1:0] slot1_instr,
    output ifu_pkg::exc_t            slot1_exc,
    output logic [31:0]              master_cnt,
    output logic [31:0]              slave_cnt
);

    // fetch to buffer
    logic                     write_en1, write_en2;
    logic [ifu_pkg::XLEN-1:0] write_addr1, write_addr2;
    logic [ifu_pkg::XLEN-1:0] write_data1, write_data2;
    logic                     write_refill1, write_refill2;
    logic                     write_invalid1, write_invalid2;
    logic                     empty, full;

    // buffer to decode
    logic                     head_valid1, head_valid2;
    logic [ifu_pkg::XLEN-1:0] head_addr1, head_addr2;
    logic [ifu_pkg::XLEN-1:0] head_data1, head_data2;
    logic                     head_refill1, head_refill2;
    logic                     head_invalid1, head_invalid2;
    logic                     read_en1, read_en2;
    logic                     delay_owed;
    logic [ifu_pkg::XLEN-1:0] slot_pc;

    // decode to result
    logic                     iss_valid1, iss_valid2;
    logic [ifu_pkg::XLEN-1:0] iss_pc1, iss_pc2;
    logic [ifu_pkg::XLEN-1:0] iss_instr1, iss_instr2;
    logic                     iss_refill1, iss_refill2;
    logic                     iss_invalid1, iss_invalid2;
    logic                     iss_delay1, iss_branch1;

    fetch_unit   u_fetch  (.*);
    inst_fifo    u_fifo   (.*);
    issue_decode u_decode (.*);
    issue_result u_result (.*);

endmodule

// File: verification/ifu_checker.sv
module ifu_checker (
    input logic          clk,
    input logic          fifo_rst,
    input logic          issue_ready,
    input logic          imem_req,
    input logic [31:0]   imem_addr,
    input logic          imem_single,
    input logic          slot0_valid,
    input logic [31:0]   slot0_pc,
    input logic [31:0]   slot0_instr,
    input ifu_pkg::exc_t slot0_exc,
    input logic          slot0_delay,
    input logic          slot1_valid,
    input logic [31:0]   slot1_pc,
    input logic [31:0]   slot1_instr,
    input ifu_pkg::exc_t slot1_exc,
    input logic [31:0]   master_cnt,
    input logic [31:0]   slave_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    int          mismatch_cnt = 0;
    int          other_cnt = 0;
    int          masters;
    int          slaves;
    int          seen;
    string       test_name = "none";
    logic        active = 1'b0;
    logic        after_branch;   // next instruction is a delay slot
    logic        ready_prev = 1'b0;
    logic [31:0] exp_pc;
    logic [31:0] branch_target;

    function automatic logic is_branch(input logic [31:0] instr);
        return instr[31:26] inside {6'h02, 6'h03, 6'h04, 6'h05};
    endfunction

    function automatic logic [31:0] target_of(input logic [31:0] pc, input logic [31:0] instr);
        if (instr[31:26] inside {6'h02, 6'h03})
            return {pc[31:28], instr[25:0], 2'b00};
        return pc + 32'd4 + {{14{instr[15]}}, instr[15:0], 2'b00};
    endfunction

    // master may pair with slave only without branches and without a RAW hazard
    function automatic logic pair_ok(input logic [31:0] m, input logic [31:0] s);
        logic [4:0] dest;
        dest = (m[31:26] inside {6'h09, 6'h23}) ? m[20:16] : 5'd0;
        if (is_branch(m) || is_branch(s))
            return 1'b0;
        if (dest != 5'd0 && (s[25:21] == dest || (s[31:26] == 6'h2b && s[20:16] == dest)))
            return 1'b0;
        return 1'b1;
    endfunction

    function automatic ifu_pkg::exc_t exc_at(input logic [31:0] pc);
        if (tb_ifu.prog_refill[pc[9:2]])
            return ifu_pkg::EXC_TLB_REFILL;   // refill first
        if (tb_ifu.prog_invalid[pc[9:2]])
            return ifu_pkg::EXC_TLB_INVALID;
        return ifu_pkg::EXC_NONE;
    endfunction

    task automatic compare(input string field, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            mismatch_cnt++;
            $display("Mismatch %s %s expected %h actual %h", test_name, field, exp, act);
        end
    endtask

    task automatic flag_failure(input string what);
        other_cnt++;
        $display("%s: %s", test_name, what);
    endtask

    // step the architectural pc past one instruction
    task automatic walk();
        logic [31:0] instr;
        instr = tb_ifu.prog[exp_pc[9:2]];
        if (after_branch) begin
            after_branch = 1'b0;
            exp_pc = branch_target;
        end else begin
            if (is_branch(instr)) begin
                after_branch = 1'b1;
                branch_target = target_of(exp_pc, instr);
            end
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic start_test(input string name, input logic [31:0] pc);
        test_name = name;
        exp_pc = pc;
        after_branch = 1'b0;
        masters = 0;
        slaves = 0;
        seen = 0;
        active = 1'b1;
    endtask

    task automatic end_test();
        @(negedge clk);
        #1;
        compare("master_cnt", masters, master_cnt);
        compare("slave_cnt", slaves, slave_cnt);
        if (slaves == 0)
            flag_failure("no instruction pair was dual-issued");
    endtask

    task automatic report();
        $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
    endtask

    always @(negedge clk) begin
        logic [31:0] m_instr;
        logic        m_delay;
        if (!fifo_rst && active) begin
            // a lone word is odd-addressed or the owed delay slot
            if (imem_req && imem_addr[2])
                compare("imem_single", 32'd1, 32'(imem_single));
            else if (imem_req && !(after_branch && imem_addr == exp_pc))
                compare("imem_single", 32'd0, 32'(imem_single));
            if (slot1_valid && !slot0_valid)
                flag_failure("slot1 valid without slot0");
            if (slot0_valid) begin
                if (!ready_prev)
                    flag_failure("instruction issued while issue_ready was low");
                m_instr = tb_ifu.prog[exp_pc[9:2]];
                m_delay = after_branch;
                compare("slot0_pc", exp_pc, slot0_pc);
                compare("slot0_instr", m_instr, slot0_instr);
                compare("slot0_exc", 32'(exc_at(exp_pc)), 32'(slot0_exc));
                compare("slot0_delay", 32'(m_delay), 32'(slot0_delay));
                walk();
                masters++;
                seen++;
                if (slot1_valid) begin
                    if (m_delay || !pair_ok(m_instr, tb_ifu.prog[exp_pc[9:2]]))
                        flag_failure("slot1 issued for a pair that may not dual-issue");
                    compare("slot1_pc", exp_pc, slot1_pc);
                    compare("slot1_instr", tb_ifu.prog[exp_pc[9:2]], slot1_instr);
                    compare("slot1_exc", 32'(exc_at(exp_pc)), 32'(slot1_exc));
                    walk();
                    slaves++;
                    seen++;
                end
            end
        end
        ready_prev = issue_ready;   // gates what shows up one cycle later
    end

endmodule

// File: verification/tb_ifu.sv
module tb_ifu;
    timeunit 1ns;
    timeprecision 1ps;

    logic                clk = 1'b0;
    logic                fifo_rst;
    logic                issue_ready;
    logic                redirect;
    logic [31:0]         redirect_pc;
    logic                imem_req;
    logic [31:0]         imem_addr;
    logic                imem_single;
    logic [31:0]         imem_rdata1, imem_rdata2;
    logic                imem_refill1, imem_refill2, imem_invalid1, imem_invalid2;
    logic                slot0_valid, slot0_delay, slot1_valid;
    logic [31:0]         slot0_pc, slot0_instr, slot1_pc, slot1_instr;
    ifu_pkg::exc_t       slot0_exc, slot1_exc;
    logic [31:0]         master_cnt, slave_cnt;

    logic [31:0]         prog [256];
    logic                prog_refill [256];
    logic                prog_invalid [256];
    logic [31:0]         rnd = 32'hd91e;
    logic                pend;          // redirect owed by the execute model
    logic [31:0]         pend_pc;
    logic                req_q = 1'b0;
    logic [31:0]         addr_q = '0;
    logic                timed_out;
    int                  cyc;

    // name, start pc, program variant, ready mode, instructions to see
    string       t_name [5] = '{"straight_full", "straight_random", "branch_full",
                                "branch_random", "exc_sparse"};
    logic [31:0] t_pc [5]    = '{32'h40, 32'h44, 32'h40, 32'h4c, 32'h48};
    int          t_var [5]   = '{0, 0, 1, 1, 2};
    int          t_ready [5] = '{0, 1, 0, 1, 2};
    int          t_count [5] = '{120, 120, 160, 160, 140};

    ifu_top i_dut (.*);
    ifu_checker i_chk (.*);

    always #20 clk = ~clk;

    function automatic logic take_bit();
        logic b;
        b = rnd[0];
        rnd = b ? (rnd >> 1) ^ 32'h80200003 : rnd >> 1;
        return b;
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
            v = (v << 1) | take_bit();
        return v;
    endfunction

    function automatic logic [31:0] branch_target(input logic [31:0] pc, input logic [31:0] ins);
        if (ins[31:26] == 6'h02)
            return {pc[31:28], ins[25:0], 2'b00};
        return pc + 32'd4 + {{14{ins[15]}}, ins[15:0], 2'b00};
    endfunction

    // variant 0 straight line, 1 taken branches, 2 branches plus TLB flags
    task automatic build_program(input int variant);
        logic        br_prev;
        int          kind;
        logic [31:0] tgt;
        logic [31:0] d;
        br_prev = 1'b0;
        for (int i = 0; i < 256; i++) begin
            prog_refill[i] = variant == 2 && i >= 40 && i < 48;
            prog_invalid[i] = variant == 2 && i >= 44 && i < 56;   // overlaps refill
            if (variant != 0 && i == 248) begin
                prog[i] = {6'h02, 26'h10};   // back to 0x40
            end else if (variant != 0 && !br_prev && i < 240 && take_bits(3) == 0) begin
                tgt = (16 + take_bits(8) % 224) * 4;
                d = tgt - i * 4 - 4;
                if (take_bit())
                    prog[i] = {6'h02, tgt[27:2]};
                else
                    prog[i] = {6'h04, 5'(take_bits(2) + 1), 5'(take_bits(2) + 1), d[17:2]};
            end else begin
                kind = take_bits(2);
                prog[i] = {kind < 2 ? 6'h09 : kind == 2 ? 6'h23 : 6'h2b,
                           5'(take_bits(2) + 1), 5'(take_bits(2) + 1), 16'(take_bits(8))};
            end
            br_prev = prog[i][31:26] inside {6'h02, 6'h04};
        end
    endtask

    // instruction memory, answers one cycle after the request
    always @(negedge clk) begin
        req_q = imem_req;
        addr_q = imem_addr;
    end

    always @(posedge clk) begin
        #2;
        if (req_q) begin
            imem_rdata1 = prog[addr_q[9:2]];
            imem_rdata2 = prog[8'(addr_q[9:2] + 1)];
            imem_refill1 = prog_refill[addr_q[9:2]];
            imem_refill2 = prog_refill[8'(addr_q[9:2] + 1)];
            imem_invalid1 = prog_invalid[addr_q[9:2]];
            imem_invalid2 = prog_invalid[8'(addr_q[9:2] + 1)];
        end
    end

    // one cycle of inputs plus the execute stage
    task automatic step(input int mode);
        @(posedge clk);
        #2;
        redirect = pend;
        redirect_pc = pend_pc;
        pend = 1'b0;
        issue_ready = mode == 0 ? 1'b1 : mode == 1 ? take_bit() : take_bit() & take_bit();
        if (slot0_valid && slot0_instr[31:26] inside {6'h02, 6'h04}) begin
            pend = 1'b1;
            pend_pc = branch_target(slot0_pc, slot0_instr);
        end
    endtask

    initial begin
        fifo_rst = 1'b1;
        issue_ready = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        {imem_rdata1, imem_rdata2} = '0;
        {imem_refill1, imem_refill2, imem_invalid1, imem_invalid2} = '0;
        pend = 1'b0;
        pend_pc = '0;
        timed_out = 1'b0;
        for (int t = 0; t < 5 && !timed_out; t++) begin
            @(posedge clk);
            #2;
            fifo_rst = 1'b1;
            issue_ready = 1'b0;
            redirect = 1'b0;
            pend = 1'b0;
            build_program(t_var[t]);
            i_chk.start_test(t_name[t], t_pc[t]);
            repeat (10) @(posedge clk);
            #2 fifo_rst = 1'b0;
            pend = 1'b1;   // first redirect gives the start pc
            pend_pc = t_pc[t];
            cyc = 0;
            while (i_chk.seen < t_count[t] && cyc < 5000) begin
                step(t_ready[t]);
                cyc++;
            end
            if (i_chk.seen < t_count[t]) begin
                i_chk.flag_failure("timeout, too few instructions issued");
                timed_out = 1'b1;
            end else begin
                i_chk.end_test();
            end
        end
        i_chk.report();
        if (i_chk.mismatch_cnt == 0 && i_chk.other_cnt == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: flist.f
rtl/ifu_pkg.sv
rtl/fetch_unit.sv
rtl/inst_fifo.sv
rtl/issue_decode.sv
rtl/issue_result.sv
rtl/ifu_top.sv
verification/ifu_checker.sv
verification/tb_ifu.sv
